// File: dual_id_stage.f
logic/alpha_isa_pkg.sv
logic/decode_types_pkg.sv
logic/inst_decoder.sv
logic/operand_select.sv
logic/id_slot.sv
logic/dual_id_stage.sv
test/id_stage_assertions.sv
test/tb_dual_id_stage.sv

// File: test/tb_dual_id_stage.sv
/*
 * Testbench for the dual-issue decode stage
 * directed tests per instruction class against a reference decode
 * model, then a random back-to-back run over both lanes
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dual_id_stage;

	localparam int n_pairs    = 34 + 5 + 11 + 18; // operates, memory, branches, halt/illegal
	localparam int pipe_len   = 32;
	localparam int max_cycles = 4 + 2 * n_pairs + pipe_len + 40; // plus margin

	// {opcode, function code, alu op} of every kept operate
	localparam logic [17*18-1:0] operate_list = {
		6'h10, 7'h20, decode_types_pkg::alu_addq, 6'h10, 7'h29, decode_types_pkg::alu_subq,
		6'h10, 7'h2d, decode_types_pkg::alu_cmpeq, 6'h10, 7'h4d, decode_types_pkg::alu_cmplt,
		6'h10, 7'h6d, decode_types_pkg::alu_cmple, 6'h10, 7'h1d, decode_types_pkg::alu_cmpult,
		6'h10, 7'h3d, decode_types_pkg::alu_cmpule, 6'h11, 7'h00, decode_types_pkg::alu_and,
		6'h11, 7'h08, decode_types_pkg::alu_bic, 6'h11, 7'h20, decode_types_pkg::alu_bis,
		6'h11, 7'h28, decode_types_pkg::alu_ornot, 6'h11, 7'h40, decode_types_pkg::alu_xor,
		6'h11, 7'h48, decode_types_pkg::alu_eqv, 6'h12, 7'h34, decode_types_pkg::alu_srl,
		6'h12, 7'h39, decode_types_pkg::alu_sll, 6'h12, 7'h3c, decode_types_pkg::alu_sra,
		6'h13, 7'h20, decode_types_pkg::alu_mulq
	};

	logic                          clock;
	logic                          rst_n;
	decode_types_pkg::fetch_slot_t slot1, slot2;
	decode_types_pkg::id_packet_t  pkt1, pkt2;
	integer                        seed;
	int                            errors, checks;

	dual_id_stage i_dut (
		.clock (clock),
		.rst_n (rst_n),
		.slot1 (slot1),
		.slot2 (slot2),
		.pkt1  (pkt1),
		.pkt2  (pkt2)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns
	end

	////////////////////////////////////////////////////////////
	// reference decode model
	////////////////////////////////////////////////////////////
	function automatic decode_types_pkg::id_packet_t ref_decode(
		input decode_types_pkg::fetch_slot_t s);
		decode_types_pkg::id_packet_t p;
		logic [5:0]                   op;
		logic [17:0]                  entry;
		op = s.inst[31:26];
		p = '0;
		p.opcode   = op;
		p.rega_idx = s.inst[25:21];
		p.opa      = {59'b0, s.inst[25:21]}; // no-op operands: register indices
		p.opb      = {59'b0, s.inst[20:16]};
		p.dest_idx = 5'd31;
		p.alu_func = decode_types_pkg::alu_addq;
		if (s.valid) begin
			if (op == 6'h00) begin // PAL, only halt kept
				p.halt    = (s.inst[25:0] == 26'h555);
				p.illegal = !p.halt;
			end else if (op[5:2] == 4'h4) begin // 0x10 to 0x13
				p.illegal  = 1'b1;
				p.dest_idx = s.inst[4:0];
				for (int i = 0; i < 17; i++) begin
					entry = operate_list[i*18 +: 18];
					if (entry[17:5] == {op, s.inst[11:5]}) begin
						p.illegal  = 1'b0;
						p.alu_func = decode_types_pkg::alu_func_e'(entry[4:0]);
					end
				end
				if (s.inst[12]) begin // literal form
					p.opb        = {56'b0, s.inst[20:13]};
					p.opb_is_imm = 1'b1;
				end
			end else if (op inside {6'h08, 6'h29, 6'h2b, 6'h2d, 6'h2f}) begin
				p.opa        = {{48{s.inst[15]}}, s.inst[15:0]};
				p.opa_is_imm = 1'b1;
				p.rd_mem     = op inside {6'h29, 6'h2b};
				p.wr_mem     = op inside {6'h2d, 6'h2f};
				if (!p.wr_mem)
					p.dest_idx = s.inst[25:21];
			end else if (op == 6'h1a) begin // jsr group
				p.opa        = ~64'h3;
				p.opa_is_imm = 1'b1;
				p.alu_func   = decode_types_pkg::alu_and;
				p.uncond_br  = 1'b1;
				p.dest_idx   = s.inst[25:21];
			end else if (op inside {6'h30, 6'h34, [6'h38:6'h3f]}) begin
				p.opa        = s.npc;
				p.opa_is_imm = 1'b1;
				p.opb        = {{41{s.inst[20]}}, s.inst[20:0], 2'b00};
				p.opb_is_imm = 1'b1;
				p.cond_br    = op[3]; // 0x38 and up
				p.uncond_br  = !op[3];
				if (!op[3])
					p.dest_idx = s.inst[25:21]; // link
			end else begin
				p.illegal = 1'b1; // fp, misc, unassigned
			end
		end
		p.valid = s.valid && !p.illegal;
		if (op[5:3] inside {3'h1, 3'h4, 3'h5})
			p.fu_sel = decode_types_pkg::fu_mem;
		else if (p.alu_func == decode_types_pkg::alu_mulq)
			p.fu_sel = decode_types_pkg::fu_mult;
		else
			p.fu_sel = decode_types_pkg::fu_adder;
		return p;
	endfunction

	function automatic logic [6:0] flag_bits(input decode_types_pkg::id_packet_t p);
		return {p.valid, p.illegal, p.halt, p.rd_mem, p.wr_mem, p.cond_br, p.uncond_br};
	endfunction

	function automatic decode_types_pkg::fetch_slot_t rand_slot(input logic [5:0] op);
		decode_types_pkg::fetch_slot_t s;
		s.inst         = $random(seed);
		s.inst[31:26]  = op;
		s.npc          = {$random(seed), $random(seed)};
		s.npc[1:0]     = 2'b00; // word aligned
		s.valid        = 1'b1;
		return s;
	endfunction

	// whole packet, or only the flags where the rest is undefined
	task automatic check_pkt(input string name, input decode_types_pkg::id_packet_t exp,
	                         input decode_types_pkg::id_packet_t act, input bit flags_only);
		checks++;
		if (flags_only) begin
			assert (flag_bits(act) == flag_bits(exp)) else begin
				errors++;
				$display("FAILED %s: expected flags %b, actual %b", name,
				         flag_bits(exp), flag_bits(act));
			end
		end else begin
			assert (act == exp) else begin
				errors++;
				$display("FAILED %s: expected %h, actual %h", name, exp, act);
			end
		end
	endtask

	task automatic issue_pair(input string name, input decode_types_pkg::fetch_slot_t s1,
	                          input decode_types_pkg::fetch_slot_t s2);
		decode_types_pkg::id_packet_t e1, e2;
		e1 = ref_decode(s1);
		e2 = ref_decode(s2);
		@(posedge clock);
		slot1 <= s1;
		slot2 <= s2;
		@(posedge clock);
		#1; // registered packet settled
		check_pkt({name, " lane1"}, e1, pkt1, e1.illegal);
		check_pkt({name, " lane2"}, e2, pkt2, e2.illegal);
	endtask

	// lane 2 runs one list entry ahead of lane 1
	task automatic run_opcodes(input string name, input logic [16*6-1:0] ops, input int n);
		decode_types_pkg::fetch_slot_t s1, s2;
		for (int i = 0; i < n; i++) begin
			s1 = rand_slot(ops[i*6 +: 6]);
			s2 = rand_slot(ops[((i + 1) % n)*6 +: 6]);
			if (s1.inst[31:28] == 4'h4)
				s1.inst[11:5] = 7'h7f; // unused operate function
			if (s2.inst[31:28] == 4'h4)
				s2.inst[11:5] = 7'h7f;
			issue_pair(name, s1, s2);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_hold;
		decode_types_pkg::fetch_slot_t s1, s2;
		s1 = rand_slot(6'h29); // ldq, would set rd_mem
		s2 = rand_slot(6'h30); // br, would set uncond_br
		@(posedge clock);
		slot1 <= s1;
		slot2 <= s2;
		@(posedge clock);
		rst_n <= 1'b1; // released after 2 cycles
		slot1 <= '0;
		slot2 <= '0;
		#1; // this edge was still inside reset
		check_pkt("reset lane1", '0, pkt1, 1'b1);
		check_pkt("reset lane2", '0, pkt2, 1'b1);
		@(posedge clock);
		#1;
		check_pkt("post reset lane1", '0, pkt1, 1'b1);
		check_pkt("post reset lane2", '0, pkt2, 1'b1);
	endtask

	task automatic all_operates;
		logic [17:0]                   entry;
		decode_types_pkg::fetch_slot_t s1, s2;
		for (int i = 0; i < 34; i++) begin
			entry = operate_list[(i/2)*18 +: 18];
			s1 = rand_slot(entry[17:12]);
			s2 = rand_slot(entry[17:12]);
			s1.inst[11:5] = entry[11:5];
			s2.inst[11:5] = entry[11:5];
			s1.inst[12]   = i[0]; // literal form on odd passes
			s2.inst[12]   = !i[0];
			issue_pair("operate", s1, s2);
		end
	endtask

	task automatic halt_and_illegal;
		decode_types_pkg::fetch_slot_t s1, s2;
		s1 = rand_slot(6'h00);
		s1.inst[25:0] = 26'h555;
		issue_pair("halt", s1, s1);
		s1 = rand_slot(6'h13);
		s1.inst[11:5] = 7'h20; // mulq, but not valid
		s1.valid      = 1'b0;
		s2 = rand_slot(6'h29);
		s2.valid      = 1'b0;
		issue_pair("invalid input", s1, s2);
		run_opcodes("illegal", {6'h10, 6'h11, 6'h12, 6'h13, 6'h14, 6'h15, 6'h16, 6'h17,
		                        6'h18, 6'h1c, 6'h31, 6'h32, 6'h33, 6'h37, 6'h09, 6'h01}, 16);
	endtask

	// new pair every edge, each checked one edge later
	task automatic back_to_back;
		decode_types_pkg::fetch_slot_t s1, s2;
		decode_types_pkg::id_packet_t  e1, e2;
		logic [31:0]                   rnd;
		for (int i = 0; i <= pipe_len; i++) begin
			rnd = $random(seed);
			s1 = rand_slot(rnd[5:0]);
			s1.valid = (rnd[8:6] != 3'd0); // mostly valid
			rnd = $random(seed);
			s2 = rand_slot(rnd[5:0]);
			s2.valid = (rnd[8:6] != 3'd0);
			@(posedge clock);
			slot1 <= s1;
			slot2 <= s2;
			#1;
			if (i > 0) begin
				check_pkt("pipeline lane1", e1, pkt1, e1.illegal);
				check_pkt("pipeline lane2", e2, pkt2, e2.illegal);
			end
			e1 = ref_decode(s1);
			e2 = ref_decode(s2);
		end
	endtask

	initial begin
		seed   = 85848;
		errors = 0;
		checks = 0;
		rst_n  = 1'b0;
		slot1  = '0;
		slot2  = '0;
		reset_hold();
		all_operates();
		run_opcodes("memory", {6'h08, 6'h29, 6'h2b, 6'h2d, 6'h2f}, 5);
		run_opcodes("branch", {6'h30, 6'h34, 6'h38, 6'h39, 6'h3a, 6'h3b,
		                       6'h3c, 6'h3d, 6'h3e, 6'h3f, 6'h1a}, 11);
		halt_and_illegal();
		back_to_back();
		errors += i_dut.i_lane1.i_assertions.fail_count;
		errors += i_dut.i_lane2.i_assertions.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial begin
		#(max_cycles * 10);
		$display("TIMEOUT: decode tests still running after %0d cycles", max_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/id_stage_assertions.sv
/*
 * Decode lane checks
 * concurrent properties on the registered packet of every lane
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions (
	input logic                          clock,
	input logic                          rst_n,
	input decode_types_pkg::fetch_slot_t slot,
	input decode_types_pkg::id_packet_t  pkt
);

	int fail_count; // failed properties so far

	// load or store, never both
	assert property (@(posedge clock) disable iff (!rst_n)
		pkt.valid |-> !(pkt.rd_mem && pkt.wr_mem))
		else begin
			fail_count++;
			$error("valid packet with both memory read and write");
		end

	assert property (@(posedge clock) disable iff (!rst_n)
		pkt.illegal |-> !pkt.valid)
		else begin
			fail_count++;
			$error("illegal packet marked valid");
		end

	// halt writes no register
	assert property (@(posedge clock) disable iff (!rst_n)
		pkt.halt |-> pkt.dest_idx == alpha_isa_pkg::zero_reg)
		else begin
			fail_count++;
			$error("halt packet with a destination register");
		end

	assert property (@(posedge clock) disable iff (!rst_n)
		pkt.valid |-> $past(slot.valid)) // one cycle of latency
		else begin
			fail_count++;
			$error("valid packet without a valid slot one cycle earlier");
		end

endmodule

bind id_slot id_stage_assertions i_assertions (
	.clock (clock),
	.rst_n (rst_n),
	.slot  (slot),
	.pkt   (pkt)
);

`default_nettype wire

// File: logic/dual_id_stage.sv
/*
 * Dual-issue decode stage
 * two independent decode lanes, one packet per lane per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module dual_id_stage (
	input  logic                         clock,
	input  logic                         rst_n,
	input  decode_types_pkg::fetch_slot_t slot1, // older of the pair
	input  decode_types_pkg::fetch_slot_t slot2,
	output decode_types_pkg::id_packet_t  pkt1,
	output decode_types_pkg::id_packet_t  pkt2
);

	// lane 1
	id_slot i_lane1 (
		.clock (clock),
		.rst_n (rst_n),
		.slot  (slot1),
		.pkt   (pkt1)
	);

	// lane 2, no cross dependency check here
	id_slot i_lane2 (
		.clock (clock),
		.rst_n (rst_n),
		.slot  (slot2),
		.pkt   (pkt2)
	);

endmodule

`default_nettype wire

// File: logic/id_slot.sv
/*
 * Decode lane
 * decoder and operand select for one fetch slot, followed by the
 * ID/dispatch pipeline register, one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module id_slot (
	input  logic                         clock,
	input  logic                         rst_n,
	input  decode_types_pkg::fetch_slot_t slot,
	output decode_types_pkg::id_packet_t  pkt
);

	decode_types_pkg::dec_ctrl_t  ctrl;
	decode_types_pkg::id_packet_t pkt_d; // combinational packet

	inst_decoder i_decoder (
		.inst       (slot.inst),
		.inst_valid (slot.valid),
		.ctrl       (ctrl)
	);

	operand_select i_operand_select (
		.inst (slot.inst),
		.npc  (slot.npc),
		.ctrl (ctrl),
		.pkt  (pkt_d)
	);

	////////////////////////////////////////////////////////////
	// ID/dispatch register
	////////////////////////////////////////////////////////////
	// no stall path, every edge takes a new packet
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			pkt <= '0; // all flags inactive
		else
			pkt <= pkt_d;
	end

endmodule

`default_nettype wire

// File: logic/operand_select.sv
/*
 * Operand select
 * immediate extraction, opA/opB muxes, destination index and
 * functional-unit class for one decoded slot
 */
`timescale 1ns/1ps
`default_nettype none

module operand_select (
	input  alpha_isa_pkg::inst_t         inst,
	input  alpha_isa_pkg::word_t         npc,
	input  decode_types_pkg::dec_ctrl_t  ctrl,
	output decode_types_pkg::id_packet_t pkt
);

	localparam int pad_w = alpha_isa_pkg::xlen - alpha_isa_pkg::reg_idx_w;

	alpha_isa_pkg::reg_idx_t rega, regb, regc;
	alpha_isa_pkg::word_t    mem_disp, br_disp, alu_imm;

	assign rega     = inst[25:21];
	assign regb     = inst[20:16];
	assign regc     = inst[4:0];
	assign mem_disp = {{48{inst[15]}}, inst[15:0]};        // sign-extended
	assign br_disp  = {{41{inst[20]}}, inst[20:0], 2'b00}; // longword offset
	assign alu_imm  = {56'b0, inst[20:13]};                // 8-bit literal

	////////////////////////////////////////////////////////////
	// operand muxes
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.opa_sel)
			decode_types_pkg::opa_is_rega:     {pkt.opa_is_imm, pkt.opa} = {1'b0, {pad_w{1'b0}}, rega};
			decode_types_pkg::opa_is_mem_disp: {pkt.opa_is_imm, pkt.opa} = {1'b1, mem_disp};
			decode_types_pkg::opa_is_npc:      {pkt.opa_is_imm, pkt.opa} = {1'b1, npc};
			default:                           {pkt.opa_is_imm, pkt.opa} = {1'b1, ~64'h3};
		endcase
		case (ctrl.opb_sel)
			decode_types_pkg::opb_is_regb:    {pkt.opb_is_imm, pkt.opb} = {1'b0, {pad_w{1'b0}}, regb};
			decode_types_pkg::opb_is_alu_imm: {pkt.opb_is_imm, pkt.opb} = {1'b1, alu_imm};
			decode_types_pkg::opb_is_br_disp: {pkt.opb_is_imm, pkt.opb} = {1'b1, br_disp};
			default:                          {pkt.opb_is_imm, pkt.opb} = '0; // unused code
		endcase
	end

	// destination and unit class
	always_comb begin
		case (ctrl.dest_sel)
			decode_types_pkg::dest_is_regc: pkt.dest_idx = regc;
			decode_types_pkg::dest_is_rega: pkt.dest_idx = rega;
			default:                        pkt.dest_idx = alpha_isa_pkg::zero_reg;
		endcase
		case (inst[31:29])
			3'h1, 3'h4, 3'h5: pkt.fu_sel = decode_types_pkg::fu_mem; // 0x08, 0x20, 0x28
			default: pkt.fu_sel = (ctrl.alu_func == decode_types_pkg::alu_mulq)
			                      ? decode_types_pkg::fu_mult : decode_types_pkg::fu_adder;
		endcase
	end

	// straight copies
	assign pkt.rega_idx  = rega;
	assign pkt.opcode    = inst[31:26];
	assign pkt.alu_func  = ctrl.alu_func;
	assign pkt.rd_mem    = ctrl.rd_mem;
	assign pkt.wr_mem    = ctrl.wr_mem;
	assign pkt.cond_br   = ctrl.cond_br;
	assign pkt.uncond_br = ctrl.uncond_br;
	assign pkt.halt      = ctrl.halt;
	assign pkt.illegal   = ctrl.illegal;
	assign pkt.valid     = ctrl.valid;

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
/*
 * Instruction decoder
 * turns one instruction word into datapath control fields,
 * purely combinational, no-op when the slot is not valid
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  alpha_isa_pkg::inst_t       inst,
	input  logic                       inst_valid, // low: output is a no-op
	output decode_types_pkg::dec_ctrl_t ctrl
);

	alpha_isa_pkg::opcode_t opcode;
	alpha_isa_pkg::func_t   func;

	assign opcode = inst[31:26];
	assign func   = inst[11:5]; // operate function field

	always_comb begin
		// no-op defaults
		ctrl.opa_sel   = decode_types_pkg::opa_is_rega;
		ctrl.opb_sel   = decode_types_pkg::opb_is_regb;
		ctrl.dest_sel  = decode_types_pkg::dest_none;
		ctrl.alu_func  = decode_types_pkg::alu_addq;
		ctrl.rd_mem    = 1'b0;
		ctrl.wr_mem    = 1'b0;
		ctrl.cond_br   = 1'b0;
		ctrl.uncond_br = 1'b0;
		ctrl.halt      = 1'b0;
		ctrl.illegal   = 1'b0;
		if (inst_valid) begin
			case (inst[31:29]) // opcode group, top three bits
				3'h0: begin // 0x00, PAL
					if (opcode == alpha_isa_pkg::pal_inst &&
					    inst[25:0] == alpha_isa_pkg::pal_halt_code)
						ctrl.halt = 1'b1;
					else
						ctrl.illegal = 1'b1;
				end
				3'h2: begin // 0x10, integer operates
					ctrl.opb_sel  = inst[12] ? decode_types_pkg::opb_is_alu_imm
					                         : decode_types_pkg::opb_is_regb;
					ctrl.dest_sel = decode_types_pkg::dest_is_regc;
					case (opcode)
						alpha_isa_pkg::inta_grp:
							case (func)
								alpha_isa_pkg::addq_func:   ctrl.alu_func = decode_types_pkg::alu_addq;
								alpha_isa_pkg::subq_func:   ctrl.alu_func = decode_types_pkg::alu_subq;
								alpha_isa_pkg::cmpeq_func:  ctrl.alu_func = decode_types_pkg::alu_cmpeq;
								alpha_isa_pkg::cmplt_func:  ctrl.alu_func = decode_types_pkg::alu_cmplt;
								alpha_isa_pkg::cmple_func:  ctrl.alu_func = decode_types_pkg::alu_cmple;
								alpha_isa_pkg::cmpult_func: ctrl.alu_func = decode_types_pkg::alu_cmpult;
								alpha_isa_pkg::cmpule_func: ctrl.alu_func = decode_types_pkg::alu_cmpule;
								default:                    ctrl.illegal = 1'b1;
							endcase
						alpha_isa_pkg::intl_grp:
							case (func)
								alpha_isa_pkg::and_func:   ctrl.alu_func = decode_types_pkg::alu_and;
								alpha_isa_pkg::bic_func:   ctrl.alu_func = decode_types_pkg::alu_bic;
								alpha_isa_pkg::bis_func:   ctrl.alu_func = decode_types_pkg::alu_bis;
								alpha_isa_pkg::ornot_func: ctrl.alu_func = decode_types_pkg::alu_ornot;
								alpha_isa_pkg::xor_func:   ctrl.alu_func = decode_types_pkg::alu_xor;
								alpha_isa_pkg::eqv_func:   ctrl.alu_func = decode_types_pkg::alu_eqv;
								default:                   ctrl.illegal = 1'b1;
							endcase
						alpha_isa_pkg::ints_grp:
							case (func)
								alpha_isa_pkg::srl_func: ctrl.alu_func = decode_types_pkg::alu_srl;
								alpha_isa_pkg::sll_func: ctrl.alu_func = decode_types_pkg::alu_sll;
								alpha_isa_pkg::sra_func: ctrl.alu_func = decode_types_pkg::alu_sra;
								default:                 ctrl.illegal = 1'b1;
							endcase
						alpha_isa_pkg::intm_grp:
							if (func == alpha_isa_pkg::mulq_func)
								ctrl.alu_func = decode_types_pkg::alu_mulq;
							else
								ctrl.illegal = 1'b1;
						// itfp, fltv, flti, fltl: no fp unit
						default: ctrl.illegal = 1'b1;
					endcase
				end
				3'h3: begin // 0x18, misc / jumps / ftpi
					if (opcode == alpha_isa_pkg::jsr_grp) begin
						// jmp, jsr, ret, jsr_co all behave the same
						ctrl.opa_sel   = decode_types_pkg::opa_is_not3;
						ctrl.alu_func  = decode_types_pkg::alu_and; // word-align target
						ctrl.dest_sel  = decode_types_pkg::dest_is_rega;
						ctrl.uncond_br = 1'b1;
					end else begin
						ctrl.illegal = 1'b1; // misc_grp, ftpi_grp, unassigned
					end
				end
				3'h1, 3'h4, 3'h5: begin // 0x08, 0x20, 0x28, memory
					ctrl.opa_sel  = decode_types_pkg::opa_is_mem_disp;
					ctrl.dest_sel = decode_types_pkg::dest_is_rega;
					case (opcode)
						alpha_isa_pkg::lda_inst: ; // address add only
						alpha_isa_pkg::ldq_inst, alpha_isa_pkg::ldq_l_inst:
							ctrl.rd_mem = 1'b1;
						alpha_isa_pkg::stq_inst, alpha_isa_pkg::stq_c_inst: begin
							ctrl.wr_mem   = 1'b1;
							ctrl.dest_sel = decode_types_pkg::dest_none;
						end
						default: ctrl.illegal = 1'b1;
					endcase
				end
				default: begin // 0x30, 0x38, branches
					ctrl.opa_sel = decode_types_pkg::opa_is_npc;
					ctrl.opb_sel = decode_types_pkg::opb_is_br_disp;
					case (opcode)
						alpha_isa_pkg::br_inst, alpha_isa_pkg::bsr_inst: begin
							ctrl.dest_sel  = decode_types_pkg::dest_is_rega; // link reg
							ctrl.uncond_br = 1'b1;
						end
						alpha_isa_pkg::fbeq_inst, alpha_isa_pkg::fblt_inst,
						alpha_isa_pkg::fble_inst, alpha_isa_pkg::fbne_inst,
						alpha_isa_pkg::fbge_inst, alpha_isa_pkg::fbgt_inst:
							ctrl.illegal = 1'b1; // fp branches
						default: ctrl.cond_br = 1'b1; // integer conditionals
					endcase
				end
			endcase
		end
		ctrl.valid = inst_valid & ~ctrl.illegal;
	end

endmodule

`default_nettype wire

// File: logic/decode_types_pkg.sv
/*
 * Decode stage control types
 * mux select and ALU enums, fetch slot and decoded packet structs
 */
`default_nettype none

package decode_types_pkg;

	typedef enum logic [4:0] {
		alu_addq, alu_subq, alu_and, alu_bic, alu_bis, alu_ornot,
		alu_xor, alu_eqv, alu_srl, alu_sll, alu_sra, alu_mulq,
		alu_cmpeq, alu_cmplt, alu_cmple, alu_cmpult, alu_cmpule
	} alu_func_e;

	typedef enum logic [1:0] {opa_is_rega, opa_is_mem_disp, opa_is_npc, opa_is_not3} opa_sel_e;
	typedef enum logic [1:0] {opb_is_regb, opb_is_alu_imm, opb_is_br_disp} opb_sel_e;
	typedef enum logic [1:0] {dest_none, dest_is_rega, dest_is_regc} dest_sel_e;
	typedef enum logic [1:0] {fu_adder, fu_mult, fu_mem} fu_sel_e;

	// one fetched instruction, 97 bits
	typedef struct packed {
		alpha_isa_pkg::inst_t inst;
		alpha_isa_pkg::word_t npc; // pc + 4
		logic                 valid;
	} fetch_slot_t;

	// raw decoder outputs, before operand muxing
	typedef struct packed {
		opa_sel_e  opa_sel;
		opb_sel_e  opb_sel;
		dest_sel_e dest_sel;
		alu_func_e alu_func;
		logic      rd_mem, wr_mem;
		logic      cond_br, uncond_br;
		logic      halt, illegal;
		logic      valid; // input valid and not illegal
	} dec_ctrl_t;

	// packet handed to dispatch
	typedef struct packed {
		alpha_isa_pkg::word_t    opa;
		logic                    opa_is_imm; // set: value, clear: register index
		alpha_isa_pkg::word_t    opb;
		logic                    opb_is_imm;
		alpha_isa_pkg::reg_idx_t dest_idx;
		alpha_isa_pkg::reg_idx_t rega_idx;
		alpha_isa_pkg::opcode_t  opcode;
		alu_func_e               alu_func;
		fu_sel_e                 fu_sel;
		logic                    rd_mem, wr_mem;
		logic                    cond_br, uncond_br;
		logic                    halt, illegal, valid;
	} id_packet_t;

endpackage

`default_nettype wire

// File: logic/alpha_isa_pkg.sv
/*
 * Alpha ISA subset encodings
 * field widths, opcodes, operate function codes and fixed register
 * values shared by the decode stage
 */
`default_nettype none

package alpha_isa_pkg;

	// field widths
	localparam int inst_w    = 32;
	localparam int xlen      = 64;
	localparam int reg_idx_w = 5;
	localparam int opcode_w  = 6;
	localparam int func_w    = 7; // operate function, inst[11:5]

	typedef logic [inst_w-1:0]    inst_t;
	typedef logic [xlen-1:0]      word_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;
	typedef logic [opcode_w-1:0]  opcode_t;
	typedef logic [func_w-1:0]    func_t;

	localparam reg_idx_t    zero_reg      = 5'd31; // r31 reads as zero
	localparam logic [25:0] pal_halt_code = 26'h0555;

	////////////////////////////////////////////////////////////
	// major opcodes
	////////////////////////////////////////////////////////////
	localparam opcode_t pal_inst = 6'h00;
	localparam opcode_t lda_inst = 6'h08;
	localparam opcode_t inta_grp = 6'h10, intl_grp = 6'h11; // integer operates
	localparam opcode_t ints_grp = 6'h12, intm_grp = 6'h13;
	localparam opcode_t itfp_grp = 6'h14, fltv_grp = 6'h15; // fp groups
	localparam opcode_t flti_grp = 6'h16, fltl_grp = 6'h17;
	localparam opcode_t misc_grp = 6'h18, jsr_grp = 6'h1a, ftpi_grp = 6'h1c;
	localparam opcode_t ldq_inst = 6'h29, ldq_l_inst = 6'h2b;
	localparam opcode_t stq_inst = 6'h2d, stq_c_inst = 6'h2f;
	localparam opcode_t br_inst  = 6'h30, bsr_inst = 6'h34;
	localparam opcode_t fbeq_inst = 6'h31, fblt_inst = 6'h32, fble_inst = 6'h33;
	localparam opcode_t fbne_inst = 6'h35, fbge_inst = 6'h36, fbgt_inst = 6'h37;

	////////////////////////////////////////////////////////////
	// operate function codes
	////////////////////////////////////////////////////////////
	localparam func_t cmpult_func = 7'h1d, addq_func = 7'h20, subq_func = 7'h29;
	localparam func_t cmpeq_func = 7'h2d, cmpule_func = 7'h3d;
	localparam func_t cmplt_func = 7'h4d, cmple_func = 7'h6d;
	localparam func_t and_func = 7'h00, bic_func = 7'h08, bis_func = 7'h20; // intl
	localparam func_t ornot_func = 7'h28, xor_func = 7'h40, eqv_func = 7'h48;
	localparam func_t srl_func = 7'h34, sll_func = 7'h39, sra_func = 7'h3c; // ints
	localparam func_t mulq_func = 7'h20; // intm

endpackage

`default_nettype wire
